//--- hw/axi_lite_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_lite_if;
   import lsu_pkg::*;

   // read request
   word_t      araddr;
   logic [2:0] arprot;
   logic       arvalid;
   logic       arready;
   // read response
   word_t      rdata;
   resp_t      rresp;
   logic       rvalid;
   logic       rready;
   // write request
   word_t      awaddr;
   logic [2:0] awprot;
   logic       awvalid;
   logic       awready;
   word_t      wdata;
   strb_t      wstrb;
   logic       wvalid;
   logic       wready;
   // write response
   resp_t      bresp;
   logic       bvalid;
   logic       bready;

   modport master (
      output araddr, arprot, arvalid, rready,
      output awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
      input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
   );

   modport slave (
      input  araddr, arprot, arvalid, rready,
      input  awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
      output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
   );

endinterface

`default_nettype wire

//--- hw/axi_lite_ram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_ram #(
   parameter int RAM_WORDS   = 256,
   parameter int READY_DELAY = 2
) (
   input wire        clk,
   input wire        rstn,
   axi_lite_if.slave bus
);
   import lsu_pkg::*;

   localparam int    IDX_W = $clog2(RAM_WORDS);
   localparam int    CNT_W = $clog2(READY_DELAY + 2);
   localparam word_t LIMIT = word_t'(RAM_WORDS);

   typedef logic [CNT_W-1:0] cnt_t;
   localparam cnt_t DELAY = cnt_t'(READY_DELAY);

   word_t mem [RAM_WORDS];

   logic  [2:0] ch_valid;
   logic  [2:0] ch_open;
   logic  [2:0] ch_ready;
   logic        ar_fire;
   logic        aw_fire;
   logic        w_fire;
   logic        aw_got;
   logic        w_got;
   logic        do_write;
   word_t       aw_addr_q;
   word_t       w_data_q;
   strb_t       w_strb_q;

   function automatic logic in_range(word_t a);
      return (a >> 2) < LIMIT;
   endfunction

   function automatic logic [IDX_W-1:0] word_idx(word_t a);
      return a[IDX_W+1:2];
   endfunction

   // channel order is ar, aw, w
   assign ch_valid = {bus.wvalid, bus.awvalid, bus.arvalid};
   assign ch_open  = {!w_got && !bus.bvalid, !aw_got && !bus.bvalid, !bus.rvalid};

   for (genvar i = 0; i < 3; i++) begin : g_ready
      cnt_t cnt;
      logic rdy;

      always_ff @(posedge clk) begin
         if (rstn) begin
            rdy <= 1'b0;
            cnt <= '0;
         end else if (rdy) begin
            rdy <= 1'b0;
            cnt <= '0;
         end else if (ch_valid[i] && ch_open[i]) begin
            if (cnt == DELAY) begin
               rdy <= 1'b1;
               cnt <= '0;
            end else begin
               cnt <= cnt + 1'b1;
            end
         end else begin
            cnt <= '0;
         end
      end

      assign ch_ready[i] = rdy;
   end

   assign bus.arready = ch_ready[0];
   assign bus.awready = ch_ready[1];
   assign bus.wready  = ch_ready[2];

   assign ar_fire  = bus.arvalid && bus.arready;
   assign aw_fire  = bus.awvalid && bus.awready;
   assign w_fire   = bus.wvalid && bus.wready;
   assign do_write = aw_got && w_got;

   always_ff @(posedge clk) begin
      if (rstn) begin
         bus.rvalid <= 1'b0;
         bus.bvalid <= 1'b0;
         aw_got     <= 1'b0;
         w_got      <= 1'b0;
      end else begin
         if (ar_fire) begin
            bus.rvalid <= 1'b1;
         end else if (bus.rvalid && bus.rready) begin
            bus.rvalid <= 1'b0;
         end
         if (aw_fire) begin
            aw_got <= 1'b1;
         end
         if (w_fire) begin
            w_got <= 1'b1;
         end
         // response goes out one edge after both halves are in
         if (do_write) begin
            aw_got     <= 1'b0;
            w_got      <= 1'b0;
            bus.bvalid <= 1'b1;
         end else if (bus.bvalid && bus.bready) begin
            bus.bvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (aw_fire) begin
         aw_addr_q <= bus.awaddr;
      end
      if (w_fire) begin
         w_data_q <= bus.wdata;
         w_strb_q <= bus.wstrb;
      end
      if (ar_fire) begin
         bus.rdata <= in_range(bus.araddr) ? mem[word_idx(bus.araddr)] : '0;
         bus.rresp <= in_range(bus.araddr) ? RESP_OKAY : RESP_SLVERR;
      end
      if (do_write) begin
         bus.bresp <= in_range(aw_addr_q) ? RESP_OKAY : RESP_SLVERR;
         for (int b = 0; b < 4; b++) begin
            if (w_strb_q[b] && in_range(aw_addr_q)) begin
               mem[word_idx(aw_addr_q)][8*b +: 8] <= w_data_q[8*b +: 8];
            end
         end
      end
   end

   a_ar_hold: assert property (@(posedge clk) disable iff (rstn)
      bus.arvalid && !bus.arready |=> bus.arvalid);

   a_aw_hold: assert property (@(posedge clk) disable iff (rstn)
      bus.awvalid && !bus.awready |=> bus.awvalid && $stable(bus.awaddr));

   // an empty strobe would complete a write that stores nothing
   a_w_strb: assert property (@(posedge clk) disable iff (rstn)
      w_fire |-> bus.wstrb != '0);

endmodule

`default_nettype wire

//--- hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

   // data and address word and the RAM word
   typedef logic [31:0] word_t;

   // one bit per byte lane
   typedef logic [3:0] strb_t;

   typedef logic [1:0] resp_t;

   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

   // destination register index, passed through untouched
   typedef logic [4:0] reg_tag_t;

   typedef enum logic [3:0] {
      OP_NONE,
      OP_LB,
      OP_LH,
      OP_LW,
      OP_LBU,
      OP_LHU,
      OP_FLW,
      OP_SB,
      OP_SH,
      OP_SW,
      OP_FSW
   } mem_op_t;

   // memory stage FSM
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_R_ADDR,
      ST_R_DATA,
      ST_W_REQ,
      ST_W_RESP
   } mem_state_t;

endpackage

`default_nettype wire

//--- hw/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
   parameter int RAM_WORDS   = 256,
   parameter int READY_DELAY = 2
) (
   input  wire                     clk,
   input  wire                     rstn,
   input  wire                     enabled,
   input  wire lsu_pkg::mem_op_t   op,
   input  wire lsu_pkg::word_t     addr,
   input  wire lsu_pkg::word_t     rs2,
   input  wire lsu_pkg::word_t     frs2,
   input  wire lsu_pkg::reg_tag_t  rd,
   output wire                     completed,
   output wire lsu_pkg::mem_op_t   op_n,
   output wire lsu_pkg::reg_tag_t  rd_n,
   output wire lsu_pkg::word_t     result,
   output wire                     misaligned,
   output wire                     bus_error
);

   axi_lite_if bus ();

   mem_stage i_mem_stage (
      .clk        (clk),
      .rstn       (rstn),
      .enabled    (enabled),
      .op         (op),
      .addr       (addr),
      .rs2        (rs2),
      .frs2       (frs2),
      .rd         (rd),
      .bus        (bus.master),
      .completed  (completed),
      .op_n       (op_n),
      .rd_n       (rd_n),
      .result     (result),
      .misaligned (misaligned),
      .bus_error  (bus_error)
   );

   axi_lite_ram #(
      .RAM_WORDS   (RAM_WORDS),
      .READY_DELAY (READY_DELAY)
   ) i_axi_lite_ram (
      .clk  (clk),
      .rstn (rstn),
      .bus  (bus.slave)
   );

endmodule

`default_nettype wire

//--- hw/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
   input  wire                     clk,
   input  wire                     rstn,
   input  wire                     enabled,
   input  wire lsu_pkg::mem_op_t   op,
   input  wire lsu_pkg::word_t     addr,
   input  wire lsu_pkg::word_t     rs2,
   input  wire lsu_pkg::word_t     frs2,
   input  wire lsu_pkg::reg_tag_t  rd,
   axi_lite_if.master              bus,
   output logic                    completed,
   output lsu_pkg::mem_op_t        op_n,
   output lsu_pkg::reg_tag_t       rd_n,
   output lsu_pkg::word_t          result,
   output logic                    misaligned,
   output logic                    bus_error
);
   import lsu_pkg::*;

   mem_state_t state;
   logic       is_load;
   logic       is_store;
   logic       misalign_in;
   word_t      st_data;
   strb_t      st_strb;
   word_t      rd_shifted;
   word_t      load_val;

   assign is_load  = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_FLW};
   assign is_store = op inside {OP_SB, OP_SH, OP_SW, OP_FSW};

   // halves need even, words need 4-byte aligned addresses
   always_comb begin
      case (op)
         OP_LH, OP_LHU, OP_SH:        misalign_in = addr[0];
         OP_LW, OP_FLW, OP_SW, OP_FSW: misalign_in = |addr[1:0];
         default:                     misalign_in = 1'b0;
      endcase
   end

   // store lane placement
   always_comb begin
      case (op)
         OP_SB: begin
            st_data = {24'b0, rs2[7:0]} << {addr[1:0], 3'b000};
            st_strb = 4'b0001 << addr[1:0];
         end
         OP_SH: begin
            st_data = {16'b0, rs2[15:0]} << {addr[1:0], 3'b000};
            st_strb = 4'b0011 << addr[1:0];
         end
         OP_SW: begin
            st_data = rs2;
            st_strb = 4'b1111;
         end
         OP_FSW: begin
            st_data = frs2;
            st_strb = 4'b1111;
         end
         default: begin
            st_data = '0;
            st_strb = '0;
         end
      endcase
   end

   // result still holds the address while the load is in flight
   assign rd_shifted = bus.rdata >> {result[1:0], 3'b000};

   always_comb begin
      case (op_n)
         OP_LB:   load_val = {{24{rd_shifted[7]}}, rd_shifted[7:0]};
         OP_LBU:  load_val = {24'b0, rd_shifted[7:0]};
         OP_LH:   load_val = {{16{rd_shifted[15]}}, rd_shifted[15:0]};
         OP_LHU:  load_val = {16'b0, rd_shifted[15:0]};
         default: load_val = bus.rdata;
      endcase
   end

   assign bus.arprot = 3'b000;
   assign bus.awprot = 3'b000;

   always_ff @(posedge clk) begin
      if (rstn) begin
         state       <= ST_IDLE;
         completed   <= 1'b0;
         misaligned  <= 1'b0;
         bus_error   <= 1'b0;
         bus.arvalid <= 1'b0;
         bus.rready  <= 1'b0;
         bus.awvalid <= 1'b0;
         bus.wvalid  <= 1'b0;
         bus.bready  <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (enabled) begin
                  misaligned <= misalign_in;
                  bus_error  <= 1'b0;
                  if (misalign_in || !(is_load || is_store)) begin
                     completed <= 1'b1;
                  end else if (is_load) begin
                     completed   <= 1'b0;
                     bus.arvalid <= 1'b1;
                     state       <= ST_R_ADDR;
                  end else begin
                     completed   <= 1'b0;
                     bus.awvalid <= 1'b1;
                     bus.wvalid  <= 1'b1;
                     state       <= ST_W_REQ;
                  end
               end
            end
            ST_R_ADDR: begin
               if (bus.arready) begin
                  bus.arvalid <= 1'b0;
                  bus.rready  <= 1'b1;
                  state       <= ST_R_DATA;
               end
            end
            ST_R_DATA: begin
               if (bus.rvalid && bus.rready) begin
                  bus.rready <= 1'b0;
                  completed  <= 1'b1;
                  bus_error  <= bus.rresp != RESP_OKAY;
                  state      <= ST_IDLE;
               end
            end
            ST_W_REQ: begin
               if (bus.awready) begin
                  bus.awvalid <= 1'b0;
               end
               if (bus.wready) begin
                  bus.wvalid <= 1'b0;
               end
               // both channels done earlier or on this edge
               if ((!bus.awvalid || bus.awready) && (!bus.wvalid || bus.wready)) begin
                  bus.bready <= 1'b1;
                  state      <= ST_W_RESP;
               end
            end
            ST_W_RESP: begin
               if (bus.bvalid) begin
                  bus.bready <= 1'b0;
                  completed  <= 1'b1;
                  bus_error  <= bus.bresp != RESP_OKAY;
                  state      <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_IDLE && enabled) begin
         op_n       <= op;
         rd_n       <= rd;
         result     <= addr;
         bus.araddr <= {addr[31:2], 2'b00};
         bus.awaddr <= {addr[31:2], 2'b00};
         bus.wdata  <= st_data;
         bus.wstrb  <= st_strb;
      end else if (state == ST_R_DATA && bus.rvalid && bus.rready) begin
         result <= (bus.rresp == RESP_OKAY) ? load_val : '0;
      end
   end

   // no new operation while one is still in flight
   a_enable_idle: assert property (@(posedge clk) disable iff (rstn)
      enabled |-> state == ST_IDLE);

   a_wstrb_set: assert property (@(posedge clk) disable iff (rstn)
      bus.wvalid |-> bus.wstrb != '0);

   a_ar_idle: assert property (@(posedge clk) disable iff (rstn)
      state == ST_IDLE |-> !bus.arvalid);

endmodule

`default_nettype wire

//--- lsu_top.f
hw/lsu_pkg.sv
hw/axi_lite_if.sv
hw/mem_stage.sv
hw/axi_lite_ram.sv
hw/lsu_top.sv
tb/tb_lsu_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the lsu_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f lsu_top.f --top-module tb_lsu_top -Mdir obj_dir -o sim_lsu_top
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_lsu_top > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "STATUS: PASS" "$log"; then
   exit 0
fi
exit 1

//--- tb/tb_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;
   import lsu_pkg::*;

   typedef struct packed {
      mem_op_t  op;
      word_t    addr;
      word_t    data;
      reg_tag_t rd;
      word_t    exp;
      logic     mis;
      logic     err;
   } row_t;

   logic     clk;
   logic     rstn;
   logic     enabled;
   mem_op_t  op;
   word_t    addr;
   word_t    rs2;
   word_t    frs2;
   reg_tag_t rd;
   wire      completed;
   mem_op_t  op_n;
   reg_tag_t rd_n;
   word_t    result;
   wire      misaligned;
   wire      bus_error;

   row_t       rows[$];
   // byte image of the 256-word RAM
   logic [7:0] ref_bytes [1024];
   integer     seed;
   int         mismatches;
   int         timeouts;
   logic       stuck;

   lsu_top #(
      .RAM_WORDS   (256),
      .READY_DELAY (2)
   ) i_lsu_top (
      .clk        (clk),
      .rstn       (rstn),
      .enabled    (enabled),
      .op         (op),
      .addr       (addr),
      .rs2        (rs2),
      .frs2       (frs2),
      .rd         (rd),
      .completed  (completed),
      .op_n       (op_n),
      .rd_n       (rd_n),
      .result     (result),
      .misaligned (misaligned),
      .bus_error  (bus_error)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic is_load_op(mem_op_t o);
      return o inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_FLW};
   endfunction

   function automatic word_t model_load(mem_op_t o, word_t a);
      int i;
      i = int'(a[9:0]);
      case (o)
         OP_LB:   return {{24{ref_bytes[i][7]}}, ref_bytes[i]};
         OP_LBU:  return {24'b0, ref_bytes[i]};
         OP_LH:   return {{16{ref_bytes[i+1][7]}}, ref_bytes[i+1], ref_bytes[i]};
         OP_LHU:  return {16'b0, ref_bytes[i+1], ref_bytes[i]};
         default: return {ref_bytes[i+3], ref_bytes[i+2], ref_bytes[i+1], ref_bytes[i]};
      endcase
   endfunction

   task automatic model_store(mem_op_t o, word_t a, word_t d);
      int i;
      int n;
      i = int'(a[9:0]);
      case (o)
         OP_SB:   n = 1;
         OP_SH:   n = 2;
         default: n = 4;
      endcase
      for (int k = 0; k < n; k++) begin
         ref_bytes[i+k] = d[8*k +: 8];
      end
   endtask

   task automatic add_row(mem_op_t o, word_t a, word_t d, logic mis, logic err);
      row_t r;
      r.op   = o;
      r.addr = a;
      r.data = d;
      r.rd   = reg_tag_t'(rows.size());
      r.mis  = mis;
      r.err  = err;
      // loads without a flag take their value from the byte model at run time
      r.exp  = (err && is_load_op(o)) ? '0 : a;
      rows.push_back(r);
   endtask

   task automatic build_table;
      word_t ra;
      word_t rdat;
      add_row(OP_NONE, 32'h1234_5678, 32'h0, 1'b0, 1'b0);
      add_row(OP_SW,  32'h0000_0000, 32'h0bad_f00d, 1'b0, 1'b0);
      add_row(OP_SW,  32'h0000_0010, 32'hdead_beef, 1'b0, 1'b0);
      add_row(OP_LW,  32'h0000_0010, 32'h0, 1'b0, 1'b0);
      add_row(OP_FLW, 32'h0000_0010, 32'h0, 1'b0, 1'b0);
      add_row(OP_FSW, 32'h0000_0014, 32'h3fc0_0000, 1'b0, 1'b0);
      add_row(OP_FLW, 32'h0000_0014, 32'h0, 1'b0, 1'b0);
      add_row(OP_LW,  32'h0000_0014, 32'h0, 1'b0, 1'b0);
      for (int k = 0; k < 4; k++) begin
         ra   = $random(seed);
         ra   = ra & 32'h0000_03fc;
         rdat = $random(seed);
         add_row(OP_SW, ra, rdat, 1'b0, 1'b0);
         add_row(OP_LW, ra, 32'h0, 1'b0, 1'b0);
      end
      // single lanes over a known word
      add_row(OP_SW, 32'h0000_0020, 32'h1122_3344, 1'b0, 1'b0);
      for (int k = 0; k < 4; k++) begin
         add_row(OP_SB, 32'h0000_0020 + k, 32'hffff_ffa0 + k, 1'b0, 1'b0);
         add_row(OP_LW, 32'h0000_0020, 32'h0, 1'b0, 1'b0);
      end
      add_row(OP_SW, 32'h0000_0024, 32'h5566_7788, 1'b0, 1'b0);
      add_row(OP_SH, 32'h0000_0024, 32'h1234_beef, 1'b0, 1'b0);
      add_row(OP_LW, 32'h0000_0024, 32'h0, 1'b0, 1'b0);
      add_row(OP_SH, 32'h0000_0026, 32'h9876_cafe, 1'b0, 1'b0);
      add_row(OP_LW, 32'h0000_0024, 32'h0, 1'b0, 1'b0);
      // sign and zero extension
      add_row(OP_SW, 32'h0000_0030, 32'h80f1_7f82, 1'b0, 1'b0);
      for (int k = 0; k < 4; k++) begin
         add_row(OP_LB,  32'h0000_0030 + k, 32'h0, 1'b0, 1'b0);
         add_row(OP_LBU, 32'h0000_0030 + k, 32'h0, 1'b0, 1'b0);
      end
      for (int k = 0; k < 4; k += 2) begin
         add_row(OP_LH,  32'h0000_0030 + k, 32'h0, 1'b0, 1'b0);
         add_row(OP_LHU, 32'h0000_0030 + k, 32'h0, 1'b0, 1'b0);
      end
      // misaligned accesses leave memory as it was
      add_row(OP_SW,  32'h0000_0040, 32'h0102_0304, 1'b0, 1'b0);
      add_row(OP_LH,  32'h0000_0041, 32'h0, 1'b1, 1'b0);
      add_row(OP_LHU, 32'h0000_0043, 32'h0, 1'b1, 1'b0);
      add_row(OP_SH,  32'h0000_0041, 32'hffff_ffff, 1'b1, 1'b0);
      add_row(OP_LW,  32'h0000_0042, 32'h0, 1'b1, 1'b0);
      add_row(OP_FLW, 32'h0000_0041, 32'h0, 1'b1, 1'b0);
      add_row(OP_SW,  32'h0000_0043, 32'hffff_ffff, 1'b1, 1'b0);
      add_row(OP_FSW, 32'h0000_0042, 32'hffff_ffff, 1'b1, 1'b0);
      add_row(OP_LW,  32'h0000_0040, 32'h0, 1'b0, 1'b0);
      // beyond the last RAM word
      add_row(OP_LW,  32'h0000_0400, 32'h0, 1'b0, 1'b1);
      add_row(OP_SW,  32'h0000_0400, 32'hffff_ffff, 1'b0, 1'b1);
      add_row(OP_LB,  32'h0001_0003, 32'h0, 1'b0, 1'b1);
      add_row(OP_FSW, 32'h0000_7ff0, 32'hffff_ffff, 1'b0, 1'b1);
      add_row(OP_LW,  32'h0000_0000, 32'h0, 1'b0, 1'b0);
   endtask

   task automatic check_row(row_t r, word_t exp);
      assert (result === exp) else begin
         mismatches++;
         $display("MISMATCH %0t: op %0d addr %h result %h expected %h",
                  $time, r.op, r.addr, result, exp);
      end
      assert (op_n === r.op && rd_n === r.rd) else begin
         mismatches++;
         $display("MISMATCH %0t: op %0d addr %h got op_n %0d rd_n %0d, expected rd %0d",
                  $time, r.op, r.addr, op_n, rd_n, r.rd);
      end
      assert (misaligned === r.mis && bus_error === r.err) else begin
         mismatches++;
         $display("MISMATCH %0t: op %0d addr %h flags mis %b err %b expected %b %b",
                  $time, r.op, r.addr, misaligned, bus_error, r.mis, r.err);
      end
   endtask

   task automatic run_row(row_t r, output logic timed_out);
      int    cycles;
      word_t exp;
      @(posedge clk);
      #2;
      enabled = 1'b1;
      op      = r.op;
      addr    = r.addr;
      rd      = r.rd;
      // the unused store source gets the inverse so a wrong pick shows up
      if (r.op == OP_FSW) begin
         frs2 = r.data;
         rs2  = ~r.data;
      end else begin
         rs2  = r.data;
         frs2 = ~r.data;
      end
      @(posedge clk);
      #2;
      enabled = 1'b0;
      cycles  = 0;
      while (!completed && cycles < 200) begin
         @(posedge clk);
         #2;
         cycles++;
      end
      timed_out = !completed;
      if (timed_out) begin
         $display("ERROR %0t: op %0d at %h did not complete within 200 cycles",
                  $time, r.op, r.addr);
      end else begin
         exp = r.exp;
         if (!r.mis && !r.err) begin
            if (is_load_op(r.op)) begin
               exp = model_load(r.op, r.addr);
            end else if (r.op != OP_NONE) begin
               model_store(r.op, r.addr, r.data);
            end
         end
         check_row(r, exp);
      end
   endtask

   initial begin
      seed       = 32'h5fe8;
      mismatches = 0;
      timeouts   = 0;
      stuck      = 1'b0;
      rstn       = 1'b1;
      enabled    = 1'b0;
      op         = OP_NONE;
      addr       = '0;
      rs2        = '0;
      frs2       = '0;
      rd         = '0;
      build_table();
      repeat (3) @(posedge clk);
      #2;
      rstn = 1'b0;
      @(posedge clk);
      #2;
      assert (completed === 1'b0 && misaligned === 1'b0 && bus_error === 1'b0) else begin
         mismatches++;
         $display("MISMATCH %0t: completed/misaligned/bus_error not cleared by reset", $time);
      end
      foreach (rows[i]) begin
         run_row(rows[i], stuck);
         if (stuck) begin
            timeouts++;
            break;
         end
      end
      $display("tb_lsu_top: %0d rows, %0d mismatches, %0d timeouts",
               rows.size(), mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
